/* Makefile */
# Verilator build and run of the static memory controller testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_smc_lite
FLIST     ?= smc_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG) || ! grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/smc_ahb_slave.sv */
// AHB-Lite slave side of the controller
// Checks each transfer, holds the request for the external access and sequences
// the OKAY and ERROR responses. Read data is latched when the FSM asks for it
module smc_ahb_slave
  import smc_pkg::*;
(
  input  logic              hclk,
  input  logic              rst,
  input  logic              hsel,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  smc_addr_t         haddr,
  input  logic [data_w-1:0] hwdata,
  input  logic              hready,      // Muxed bus ready
  input  logic [data_w-1:0] data_smc,    // External read data
  input  logic              done,        // Last trail cycle
  input  logic              latch_data,  // Last wait-state cycle
  output logic              start,
  output smc_addr_t         req_addr,
  output logic [1:0]        req_size,
  output logic              req_write,
  output logic [data_w-1:0] req_wdata,
  output logic              smc_hready,
  output logic [1:0]        smc_hresp,
  output logic [data_w-1:0] smc_hrdata
);

  logic              accept;     // Address phase taken this cycle
  logic              legal;      // Size and alignment fine
  logic              start_err;  // Accepted but refused
  logic              wait_okay;  // Waiting on the external access
  logic              wait_err;   // First ERROR cycle
  logic              wr_phase;   // First data-phase cycle, hwdata valid
  smc_addr_t         addr_q;
  logic [1:0]        size_q;
  logic              write_q;
  logic [data_w-1:0] wdata_q;

  //------------------------------------------------------------
  // Transfer qualification
  //------------------------------------------------------------
  assign accept = hsel && hready && (htrans == htrans_nonseq || htrans == htrans_seq);

  always_comb begin
    case (hsize)
      hsize_byte: legal = 1'b1;
      hsize_half: legal = !haddr.word.lane[0];
      hsize_word: legal = (haddr.word.lane == '0);
      default:    legal = 1'b0;  // Wider than the bus
    endcase
  end

  assign start     = accept && legal;   // FSM leaves IDLE on the accept edge
  assign start_err = accept && !legal;

  // New request goes straight through in its address phase, then the held copy
  assign req_addr  = start ? haddr : addr_q;
  assign req_size  = start ? hsize[1:0] : size_q;
  assign req_write = start ? hwrite : write_q;
  assign req_wdata = wr_phase ? hwdata : wdata_q;  // hwdata arrives one cycle late

  always_ff @(posedge hclk) begin
    if (start) begin
      addr_q  <= haddr;
      size_q  <= hsize[1:0];
      write_q <= hwrite;
    end
    if (wr_phase) wdata_q <= hwdata;
    if (latch_data) smc_hrdata <= data_smc;  // Sampled while the read strobe is low
  end

  //------------------------------------------------------------
  // Response sequencing
  //------------------------------------------------------------
  assign wait_okay = !smc_hready && (smc_hresp == hresp_okay);
  assign wait_err  = !smc_hready && (smc_hresp == hresp_error);

  always_ff @(posedge hclk) begin
    if (rst) begin
      wr_phase   <= 1'b0;
      smc_hready <= 1'b1;
      smc_hresp  <= hresp_okay;
    end else begin
      wr_phase <= start;
      if (wait_err) begin
        smc_hready <= 1'b1;           // Second ERROR cycle, ready high
      end else if (wait_okay) begin
        if (done) smc_hready <= 1'b1; // Return cycle
      end else if (start) begin
        smc_hready <= 1'b0;
        smc_hresp  <= hresp_okay;
      end else if (start_err) begin
        smc_hready <= 1'b0;
        smc_hresp  <= hresp_error;
      end else begin
        smc_hresp <= hresp_okay;
      end
    end
  end

endmodule

/* hdl/smc_lite.sv */
// Static memory controller top level
// Bridges single AHB-Lite transfers onto an asynchronous SRAM-style 32-bit bus
module smc_lite
  import smc_pkg::*;
(
  input  logic              hclk,
  input  logic              rst,
  // AHB-Lite slave port
  input  logic              hsel,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [addr_w-1:0] haddr,
  input  logic [data_w-1:0] hwdata,
  input  logic              hready,
  output logic [data_w-1:0] smc_hrdata,
  output logic              smc_hready,
  output logic [1:0]        smc_hresp,
  // External memory bus
  input  logic [data_w-1:0] data_smc,
  output logic [addr_w-1:0] smc_addr,
  output logic [data_w-1:0] smc_data,
  output logic [lane_n-1:0] smc_n_be,
  output logic              smc_n_cs,
  output logic              smc_n_rd,
  output logic [lane_n-1:0] smc_n_we,
  output logic              smc_n_wr,
  output logic              smc_n_ext_oe,
  output logic              smc_busy
);

  logic              start;        // Slave to FSM
  logic              done;
  logic              latch_data;
  logic              next_cs;      // FSM lookahead levels
  logic              next_strobe;
  smc_addr_t         req_addr;     // Held request
  logic [1:0]        req_size;
  logic              req_write;
  logic [data_w-1:0] req_wdata;

  smc_ahb_slave u_ahb_slave (
    .hclk, .rst, .hsel, .htrans, .hwrite, .hsize,
    .haddr      (haddr),
    .hwdata, .hready, .data_smc, .done, .latch_data, .start,
    .req_addr, .req_size, .req_write, .req_wdata,
    .smc_hready, .smc_hresp, .smc_hrdata
  );

  smc_timing_fsm u_timing_fsm (
    .hclk, .rst, .start, .next_cs, .next_strobe, .latch_data, .done
  );

  smc_strobe_gen u_strobe_gen (
    .hclk, .rst, .next_cs, .next_strobe,
    .req_addr, .req_size, .req_write, .req_wdata,
    .smc_addr, .smc_data, .smc_n_be, .smc_n_cs, .smc_n_rd,
    .smc_n_we, .smc_n_wr, .smc_n_ext_oe, .smc_busy
  );

endmodule

/* hdl/smc_pkg.sv */
// Shared widths, access timing, FSM codes and AHB encodings for the static memory controller
// Imported by every controller module and by the testbench
package smc_pkg;

  //------------------------------------------------------------
  // Bus widths
  //------------------------------------------------------------
  localparam int addr_w = 32;  // AHB and external address
  localparam int data_w = 32;  // AHB and external data
  localparam int lane_n = 4;   // Byte lanes per word

  //------------------------------------------------------------
  // External access timing in hclk cycles
  //------------------------------------------------------------
  // Each of the three phases lasts at least one cycle
  localparam int cs_lead_cycles  = 1;  // CS low before strobe
  localparam int wait_states     = 2;  // Read or write strobe low
  localparam int cs_trail_cycles = 1;  // Bus float after CS rises
  localparam int access_cycles   = cs_lead_cycles + wait_states + cs_trail_cycles + 1;
  localparam int cnt_w           = 4;  // Phase down-counter width

  // Timing FSM state codes
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_lead  = 2'd1;
  localparam logic [1:0] st_wait  = 2'd2;
  localparam logic [1:0] st_trail = 2'd3;

  //------------------------------------------------------------
  // AHB encodings
  //------------------------------------------------------------
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;
  localparam logic [2:0] hsize_byte    = 3'b000;
  localparam logic [2:0] hsize_half    = 3'b001;
  localparam logic [2:0] hsize_word    = 3'b010;
  localparam logic [1:0] hresp_okay    = 2'b00;
  localparam logic [1:0] hresp_error   = 2'b01;

  // Captured address as a flat byte address or as word index plus lane
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [addr_w-$clog2(lane_n)-1:0] index;  // Word on the external bus
      logic [$clog2(lane_n)-1:0]        lane;   // Byte within the word
    } word;
  } smc_addr_t;

endpackage

/* hdl/smc_strobe_gen.sv */
// External bus output stage
// Decodes byte enables and registers every pin from the FSM lookahead levels,
// so chip select and strobes change on clean clock edges
module smc_strobe_gen
  import smc_pkg::*;
(
  input  logic              hclk,
  input  logic              rst,
  input  logic              next_cs,
  input  logic              next_strobe,
  input  smc_addr_t         req_addr,
  input  logic [1:0]        req_size,
  input  logic              req_write,
  input  logic [data_w-1:0] req_wdata,
  output logic [addr_w-1:0] smc_addr,
  output logic [data_w-1:0] smc_data,
  output logic [lane_n-1:0] smc_n_be,
  output logic              smc_n_cs,
  output logic              smc_n_rd,
  output logic [lane_n-1:0] smc_n_we,
  output logic              smc_n_wr,
  output logic              smc_n_ext_oe,
  output logic              smc_busy
);

  logic [lane_n-1:0] be;       // Active-high lane select
  logic              rd_next;  // Read strobe next cycle
  logic              wr_next;  // Write strobe next cycle

  always_comb begin
    case ({1'b0, req_size})
      hsize_byte: be = lane_n'(1) << req_addr.word.lane;
      hsize_half: be = req_addr.word.lane[1] ? 4'b1100 : 4'b0011;
      default:    be = '1;  // Full word
    endcase
  end

  assign rd_next = next_strobe && !req_write;
  assign wr_next = next_strobe && req_write;

  // Address and data follow the request while CS is due
  always_ff @(posedge hclk) begin
    if (next_cs) smc_addr <= {req_addr.word.index, 2'b00};  // Word address
    if (next_cs && req_write) smc_data <= req_wdata;
  end

  //------------------------------------------------------------
  // Control pins, all active low except busy
  //------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_n_be     <= '1;
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_wr     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
    end else begin
      smc_n_be     <= next_cs ? ~be : '1;
      smc_n_cs     <= !next_cs;
      smc_n_rd     <= !rd_next;
      smc_n_we     <= wr_next ? ~be : '1;    // Only selected lanes strobe
      smc_n_wr     <= !wr_next;
      smc_n_ext_oe <= !(next_cs && req_write); // Drive data for the whole write
      smc_busy     <= next_cs;
    end
  end

endmodule

/* hdl/smc_timing_fsm.sv */
// External access sequencer
// Steps IDLE, LEAD, WAIT and TRAIL from one start pulse and gives lookahead
// chip-select and strobe levels, the read latch pulse and done
module smc_timing_fsm
  import smc_pkg::*;
(
  input  logic hclk,
  input  logic rst,
  input  logic start,        // Good transfer accepted
  output logic next_cs,      // CS level for the following cycle
  output logic next_strobe,  // Strobe level for the following cycle
  output logic latch_data,   // Last wait-state cycle
  output logic done          // Last trail cycle
);

  logic [1:0]       state;
  logic [1:0]       state_nxt;
  logic [cnt_w-1:0] cnt;      // Cycles left in this phase, minus one
  logic [cnt_w-1:0] cnt_nxt;
  logic             last;     // Final cycle of a timed phase

  // Reload values
  localparam logic [cnt_w-1:0] lead_load  = cnt_w'(cs_lead_cycles - 1);
  localparam logic [cnt_w-1:0] wait_load  = cnt_w'(wait_states - 1);
  localparam logic [cnt_w-1:0] trail_load = cnt_w'(cs_trail_cycles - 1);

  assign last = (cnt == '0);

  //------------------------------------------------------------
  // Next state and counter
  //------------------------------------------------------------
  always_comb begin
    state_nxt  = state;
    cnt_nxt    = last ? cnt : cnt - 1'b1;
    latch_data = 1'b0;
    done       = 1'b0;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_lead;
          cnt_nxt   = lead_load;
        end
      end
      st_lead: begin
        if (last) begin
          state_nxt = st_wait;
          cnt_nxt   = wait_load;
        end
      end
      st_wait: begin
        if (last) begin
          state_nxt  = st_trail;
          cnt_nxt    = trail_load;
          latch_data = 1'b1;  // Read data settled at strobe end
        end
      end
      st_trail: begin
        if (last) begin
          state_nxt = st_idle;
          done      = 1'b1;   // Slave raises ready next cycle
        end
      end
      default: begin
        state_nxt = st_idle;
        cnt_nxt   = '0;
      end
    endcase
  end

  // Pins follow state_nxt one register later, so they match state exactly
  assign next_cs     = (state_nxt == st_lead) || (state_nxt == st_wait);
  assign next_strobe = (state_nxt == st_wait);

  //------------------------------------------------------------
  // State registers
  //------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

endmodule

/* smc_lite.f */
hdl/smc_pkg.sv
hdl/smc_ahb_slave.sv
hdl/smc_timing_fsm.sv
hdl/smc_strobe_gen.sv
hdl/smc_lite.sv
tb/smc_lite_sva.sv
tb/tb_smc_lite.sv

/* tb/smc_lite_sva.sv */
// Concurrent checks of the AHB responses and external bus timing of smc_lite
// Follows each accepted transfer from the bus side and compares the pins with it
module smc_lite_sva
  import smc_pkg::*;
(
  input logic              hclk, rst, hsel, hwrite, hready,
  input logic [1:0]        htrans,
  input logic [2:0]        hsize,
  input logic [addr_w-1:0] haddr, smc_addr,
  input logic [data_w-1:0] hwdata, smc_hrdata, smc_data,
  input logic              smc_hready, smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_busy,
  input logic [1:0]        smc_hresp,
  input logic [lane_n-1:0] smc_n_be, smc_n_we
);

  int          phase;       // Data-phase cycle of a good access, 0 when none
  int          err_phase;   // ERROR response cycle, 0 when none
  int          fail_count = 0;
  logic        accept;
  logic        legal;
  logic        acc_write;   // Last accepted transfer
  logic [2:0]  acc_size;
  logic [31:0] acc_addr;
  logic [31:0] acc_wdata;
  logic [3:0]  exp_be;
  logic        cs_win;      // CS due low
  logic        strobe_win;  // Read or write strobe due low

  // Word the SRAM model returns for a word address
  function automatic logic [31:0] expected_rdata(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  task automatic note_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  //------------------------------------------------------------
  // Transfer tracking
  //------------------------------------------------------------
  assign accept = hsel && hready && (htrans == htrans_nonseq || htrans == htrans_seq);
  assign legal  = (hsize == hsize_byte) || (hsize == hsize_half && !haddr[0])
                  || (hsize == hsize_word && haddr[1:0] == 2'b00);
  assign cs_win     = phase >= 1 && phase <= cs_lead_cycles + wait_states;
  assign strobe_win = phase > cs_lead_cycles && phase <= cs_lead_cycles + wait_states;

  always_comb begin
    case (acc_size)
      hsize_byte: exp_be = 4'b0001 << acc_addr[1:0];
      hsize_half: exp_be = acc_addr[1] ? 4'b1100 : 4'b0011;
      default:    exp_be = 4'b1111;
    endcase
  end

  always_ff @(posedge hclk) begin
    if (rst) begin
      phase     <= 0;
      err_phase <= 0;
    end else begin
      if (accept && legal) phase <= 1;
      else if (phase != 0 && phase < access_cycles) phase <= phase + 1;
      else phase <= 0;
      if (accept && !legal) err_phase <= 1;
      else if (err_phase == 1) err_phase <= 2;  // Second ERROR cycle
      else err_phase <= 0;
      if (accept) begin
        acc_write <= hwrite;
        acc_size  <= hsize;
        acc_addr  <= haddr;
      end
      if (phase == 1) acc_wdata <= hwdata;  // Write data of the first data cycle
    end
  end

  //------------------------------------------------------------
  // Assertions
  //------------------------------------------------------------
  a_idle: assert property (@(posedge hclk) disable iff (rst) phase == 0 && err_phase == 0
    |-> smc_hready && smc_hresp == hresp_okay && smc_n_cs && smc_n_rd && smc_n_wr
        && smc_n_we == 4'hf && smc_n_be == 4'hf && smc_n_ext_oe && !smc_busy)
    else note_failure($sformatf("Control outputs not at idle levels at t=%0t", $time));
  a_ready: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_hready == (phase == access_cycles))
    else note_failure($sformatf("MISMATCH t=%0t smc_hready got %b expected %b",
      $time, smc_hready, phase == access_cycles));
  a_resp: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_hresp == hresp_okay)
    else note_failure($sformatf("MISMATCH t=%0t smc_hresp got %b expected %b",
      $time, smc_hresp, hresp_okay));
  a_cs: assert property (@(posedge hclk) disable iff (rst) phase != 0 |-> smc_n_cs == !cs_win)
    else note_failure($sformatf("MISMATCH t=%0t smc_n_cs got %b expected %b",
      $time, smc_n_cs, !cs_win));
  a_busy: assert property (@(posedge hclk) disable iff (rst) phase != 0 |-> smc_busy == cs_win)
    else note_failure($sformatf("MISMATCH t=%0t smc_busy got %b expected %b",
      $time, smc_busy, cs_win));
  a_addr: assert property (@(posedge hclk) disable iff (rst)
    cs_win |-> smc_addr == {acc_addr[31:2], 2'b00})
    else note_failure($sformatf("MISMATCH t=%0t smc_addr got %h expected %h",
      $time, smc_addr, {acc_addr[31:2], 2'b00}));
  a_be: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_n_be == (cs_win ? ~exp_be : 4'hf))
    else note_failure($sformatf("MISMATCH t=%0t smc_n_be got %b expected %b",
      $time, smc_n_be, cs_win ? ~exp_be : 4'hf));
  a_rd: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_n_rd == !(strobe_win && !acc_write))
    else note_failure($sformatf("MISMATCH t=%0t smc_n_rd got %b expected %b",
      $time, smc_n_rd, !(strobe_win && !acc_write)));
  a_we: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_n_we == ((strobe_win && acc_write) ? ~exp_be : 4'hf))
    else note_failure($sformatf("MISMATCH t=%0t smc_n_we got %b expected %b",
      $time, smc_n_we, (strobe_win && acc_write) ? ~exp_be : 4'hf));
  a_wr: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_n_wr == !(strobe_win && acc_write))
    else note_failure($sformatf("MISMATCH t=%0t smc_n_wr got %b expected %b",
      $time, smc_n_wr, !(strobe_win && acc_write)));
  a_oe: assert property (@(posedge hclk) disable iff (rst)
    phase != 0 |-> smc_n_ext_oe == !(cs_win && acc_write))
    else note_failure($sformatf("MISMATCH t=%0t smc_n_ext_oe got %b expected %b",
      $time, smc_n_ext_oe, !(cs_win && acc_write)));
  a_wdata: assert property (@(posedge hclk) disable iff (rst)
    strobe_win && acc_write |-> smc_data == acc_wdata)
    else note_failure($sformatf("MISMATCH t=%0t smc_data got %h expected %h",
      $time, smc_data, acc_wdata));
  a_rdata: assert property (@(posedge hclk) disable iff (rst) phase == access_cycles && !acc_write
    |-> smc_hrdata == expected_rdata({acc_addr[31:2], 2'b00}))
    else note_failure($sformatf("MISMATCH t=%0t smc_hrdata got %h expected %h",
      $time, smc_hrdata, expected_rdata({acc_addr[31:2], 2'b00})));
  a_err: assert property (@(posedge hclk) disable iff (rst) err_phase != 0
    |-> smc_hresp == hresp_error && smc_hready == (err_phase == 2) && smc_n_cs)
    else note_failure($sformatf("Bad ERROR response or chip select at t=%0t", $time));

endmodule

bind smc_lite smc_lite_sva u_sva (.*);

/* tb/tb_smc_lite.sv */
// Testbench for the static memory controller
// Runs directed and random AHB transfers against an SRAM model; bound assertions check
module tb_smc_lite
  import smc_pkg::*;
();

  localparam int clk_period = 10;
  localparam int n_xfers    = 44;  // Directed plus random

  logic              hclk, rst, hsel, hwrite, hready;
  logic [1:0]        htrans;
  logic [2:0]        hsize;
  logic [addr_w-1:0] haddr, smc_addr;
  logic [data_w-1:0] hwdata, data_smc, smc_hrdata, smc_data;
  logic              smc_hready, smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_busy;
  logic [1:0]        smc_hresp;
  logic [lane_n-1:0] smc_n_be, smc_n_we;

  smc_lite UUT (.*);

  // SRAM model, word from the whole word address while read strobe is low
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem_word(smc_addr) : '0;
  assign hready   = rst ? 1'b1 : smc_hready;  // Only slave on the bus

  initial begin
    hclk = 1'b0;
    forever #(clk_period / 2) hclk = ~hclk;
  end

  // Address phase now, returns one unit into the first data-phase cycle
  task automatic ahb_transfer(input logic wr, input logic [2:0] size,
                              input logic [31:0] addr, input logic [31:0] wdata);
    hsel   = 1'b1;
    htrans = htrans_nonseq;
    hwrite = wr;
    hsize  = size;
    haddr  = addr;
    while (!hready) begin  // Overlaps the previous data phase
      @(posedge hclk);
      #1;
    end
    @(posedge hclk);
    #1;
    hsel   = 1'b0;
    htrans = 2'b00;  // IDLE
    hwdata = wdata;
  endtask

  //------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    void'($urandom(99836));
    rst    = 1'b1;
    hsel   = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hsize  = hsize_word;
    haddr  = '0;
    hwdata = '0;
    repeat (4) @(posedge hclk);
    #1;
    rst = 1'b0;
    ahb_transfer(1'b0, hsize_word, 32'h0000_1000, '0);           // Word read
    ahb_transfer(1'b1, hsize_byte, 32'h0000_2003, 32'ha1b2_c3d4); // Top lane write
    ahb_transfer(1'b1, hsize_half, 32'h0000_2001, 32'h1234_5678); // Misaligned
    ahb_transfer(1'b0, 3'b011, 32'h0000_3000, '0);                // Wider than bus
    for (int i = 4; i < n_xfers; i++) begin
      r    = $urandom;
      addr = $urandom;
      ahb_transfer(r[2], {1'b0, r[1:0]}, {12'h000, addr[19:0]}, $urandom);
      if (r[4:3] != 2'b00) begin
        repeat (r[4:3]) @(posedge hclk);
        #1;
      end
    end
    while (!hready) begin
      @(posedge hclk);
      #1;
    end
    repeat (3) @(posedge hclk);
    #1;
    if (UUT.u_sva.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Assertion failures seen");
    end
  end

  //------------------------------------------------------------
  // First failure and watchdog
  //------------------------------------------------------------
  always @(negedge hclk) begin
    if (UUT.u_sva.fail_count != 0) begin
      $display("Finished with errors");
      $fatal(1, "Stopped at the first failed check");
    end
  end

  initial begin
    // Each transfer takes at most access_cycles plus three idle cycles
    #((n_xfers * (access_cycles + 3) + 30) * clk_period);
    $display("Timeout: the transfers did not complete in time");
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule
